//--- verilog/led_strip_settings.svh
`ifndef LED_STRIP_SETTINGS_SVH
`define LED_STRIP_SETTINGS_SVH

// pixel memory geometry
`define LED_MAX_PIXELS 64
`define LED_PIX_ADDR_W 6

// apb byte address width
`define LED_APB_ADDR_W 12

// timing register reset values, in clk cycles
`define LED_T0H_RST    4
`define LED_T1H_RST    8
`define LED_TBIT_RST   12
`define LED_TRESET_RST 50

`endif

//--- verilog/led_strip_pkg.sv
`include "led_strip_settings.svh"

package led_strip_pkg;

    // grb colour word, green in bits 23:16
    typedef logic [23:0] pixel_t;

    typedef logic [`LED_PIX_ADDR_W-1:0] pix_addr_t;

    // cycle counts for pulse widths, bit period and latch gap
    typedef logic [15:0] tcount_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HIGH,
        ST_LOW,
        ST_LATCH
    } enc_state_t;

endpackage

//--- verilog/led_apb_regs.sv
`timescale 1ns/1ns
`include "led_strip_settings.svh"

module led_apb_regs (
    input  logic                         clk,
    input  logic                         nreset,
    input  logic [`LED_APB_ADDR_W-1:0]   paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [31:0]                  pwdata,
    input  logic                         busy,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         start,
    output led_strip_pkg::pix_addr_t     length,
    output led_strip_pkg::tcount_t       t0h,
    output led_strip_pkg::tcount_t       t1h,
    output led_strip_pkg::tcount_t       tbit,
    output led_strip_pkg::tcount_t       treset,
    output logic                         wr_en,
    output led_strip_pkg::pix_addr_t     wr_addr,
    output led_strip_pkg::pixel_t        wr_data
);

    localparam logic [`LED_APB_ADDR_W-1:0] ADDR_CTRL   = 'h000;
    localparam logic [`LED_APB_ADDR_W-1:0] ADDR_STATUS = 'h004;
    localparam logic [`LED_APB_ADDR_W-1:0] ADDR_LENGTH = 'h008;
    localparam logic [`LED_APB_ADDR_W-1:0] ADDR_T0H    = 'h00C;
    localparam logic [`LED_APB_ADDR_W-1:0] ADDR_T1H    = 'h010;
    localparam logic [`LED_APB_ADDR_W-1:0] ADDR_TBIT   = 'h014;
    localparam logic [`LED_APB_ADDR_W-1:0] ADDR_TRESET = 'h018;

    logic        setup_ph;
    logic        wr_acc;
    logic        sel_pixel;
    logic        sel_reg;
    logic [31:0] rd_mux;

    assign setup_ph = psel && !penable;
    assign wr_acc   = psel && penable && pwrite;

    // word aligned pixel window 0x100 to 0x1fc
    assign sel_pixel = (paddr[`LED_APB_ADDR_W-1:8] == 'h1) && (paddr[1:0] == 2'b00);

    assign pready = 1'b1;   // no wait states

    // ########################################
    // read decode
    // ########################################

    always_comb begin
        rd_mux  = 32'd0;
        sel_reg = 1'b1;
        case (paddr)
            ADDR_CTRL:   rd_mux = 32'd0;    // start is write-one and self clearing
            ADDR_STATUS: rd_mux = {31'd0, busy};
            ADDR_LENGTH: rd_mux = {{(32-`LED_PIX_ADDR_W){1'b0}}, length};
            ADDR_T0H:    rd_mux = {16'd0, t0h};
            ADDR_T1H:    rd_mux = {16'd0, t1h};
            ADDR_TBIT:   rd_mux = {16'd0, tbit};
            ADDR_TRESET: rd_mux = {16'd0, treset};
            default:     sel_reg = 1'b0;
        endcase
    end

    // ########################################
    // registers
    // ########################################

    // prdata and pslverr are captured in the setup phase and valid in access
    always_ff @(posedge clk) begin
        if (!nreset) begin
            prdata  <= 32'd0;
            pslverr <= 1'b0;
            start   <= 1'b0;
            length  <= '0;
            t0h     <= `LED_T0H_RST;
            t1h     <= `LED_T1H_RST;
            tbit    <= `LED_TBIT_RST;
            treset  <= `LED_TRESET_RST;
        end else begin
            prdata  <= (setup_ph && !pwrite) ? rd_mux : 32'd0;
            pslverr <= setup_ph && !(sel_reg || sel_pixel);
            start   <= 1'b0;
            if (wr_acc) begin
                case (paddr)
                    ADDR_CTRL:   start  <= pwdata[0] && !busy;
                    ADDR_LENGTH: length <= pwdata[`LED_PIX_ADDR_W-1:0];
                    ADDR_T0H:    t0h    <= pwdata[15:0];
                    ADDR_T1H:    t1h    <= pwdata[15:0];
                    ADDR_TBIT:   tbit   <= pwdata[15:0];
                    ADDR_TRESET: treset <= pwdata[15:0];
                    default: begin
                    end
                endcase
            end
        end
    end

    // pixel writes go straight to the memory port
    assign wr_en   = wr_acc && sel_pixel;
    assign wr_addr = paddr[`LED_PIX_ADDR_W+1:2];
    assign wr_data = pwdata[23:0];

endmodule

//--- verilog/pixel_ram.sv
`timescale 1ns/1ns
`include "led_strip_settings.svh"

module pixel_ram (
    input  logic                      clk,
    input  logic                      wr_en,
    input  led_strip_pkg::pix_addr_t  wr_addr,
    input  led_strip_pkg::pixel_t     wr_data,
    input  led_strip_pkg::pix_addr_t  rd_addr,
    output led_strip_pkg::pixel_t     rd_data
);
    import led_strip_pkg::*;

    pixel_t mem [0:`LED_MAX_PIXELS-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data one cycle after rd_addr
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- verilog/ws2812_encoder.sv
`timescale 1ns/1ns

module ws2812_encoder (
    input  logic                      clk,
    input  logic                      nreset,
    input  logic                      start,
    input  led_strip_pkg::pix_addr_t  length,
    input  led_strip_pkg::tcount_t    t0h,
    input  led_strip_pkg::tcount_t    t1h,
    input  led_strip_pkg::tcount_t    tbit,
    input  led_strip_pkg::tcount_t    treset,
    input  led_strip_pkg::pixel_t     rd_data,
    output led_strip_pkg::pix_addr_t  rd_addr,
    output logic                      busy,
    output logic                      dout
);
    import led_strip_pkg::*;

    enc_state_t state;
    tcount_t    cnt;            // cycles into current bit or latch gap
    tcount_t    t0h_q;
    tcount_t    t1h_q;
    tcount_t    tbit_q;
    tcount_t    treset_q;
    pix_addr_t  len_q;
    pixel_t     shift;          // msb is the bit on the line
    logic [4:0] bit_idx;
    logic       last_pix;       // shift holds the final pixel of the frame

    tcount_t    high_len;
    logic       bit_end;
    logic       last_bit;
    logic       next_bit;
    logic       load_word;
    logic       load_cfg;

    assign high_len  = shift[23] ? t1h_q : t0h_q;
    assign bit_end   = (cnt == tbit_q - 16'd1);
    assign last_bit  = (bit_idx == 5'd23);
    assign load_cfg  = (state == ST_IDLE) && start;
    assign next_bit  = (state == ST_LOW) && bit_end && !(last_bit && last_pix);
    assign load_word = next_bit && last_bit;

    // ########################################
    // sequencer
    // ########################################

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state    <= ST_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            last_pix <= 1'b0;
            rd_addr  <= '0;
            busy     <= 1'b0;
            dout     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    rd_addr <= '0;  // pixel 0 is read while waiting
                    if (start) begin
                        // land on the end of a bit so the low state loads pixel 0
                        state    <= ST_LOW;
                        cnt      <= tbit - 16'd1;
                        bit_idx  <= 5'd23;
                        last_pix <= 1'b0;
                        busy     <= 1'b1;
                    end
                end
                ST_HIGH: begin
                    cnt <= cnt + 16'd1;
                    if (cnt == high_len - 16'd1) begin
                        dout  <= 1'b0;
                        state <= ST_LOW;
                    end
                end
                ST_LOW: begin
                    if (next_bit) begin
                        cnt   <= '0;
                        dout  <= 1'b1;
                        state <= ST_HIGH;
                        if (load_word) begin
                            bit_idx  <= '0;
                            last_pix <= (rd_addr == len_q);
                            rd_addr  <= rd_addr + 1'b1;    // prefetch next word
                        end else begin
                            bit_idx <= bit_idx + 5'd1;
                        end
                    end else if (bit_end) begin
                        cnt   <= '0;    // frame done so hold the line low
                        state <= ST_LATCH;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                ST_LATCH: begin
                    cnt <= cnt + 16'd1;
                    if (cnt == treset_q - 16'd1) begin
                        state <= ST_IDLE;
                        busy  <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ########################################
    // frame settings and shifter
    // ########################################

    always_ff @(posedge clk) begin
        if (load_cfg) begin
            len_q    <= length;
            t0h_q    <= t0h;
            t1h_q    <= t1h;
            tbit_q   <= tbit;
            treset_q <= treset;
        end
        if (load_word) begin
            shift <= rd_data;
        end else if (next_bit) begin
            shift <= shift << 1;
        end
    end

endmodule

//--- verilog/led_strip_top.sv
`timescale 1ns/1ns
`include "led_strip_settings.svh"

module led_strip_top (
    input  logic                        clk,
    input  logic                        nreset,
    input  logic [`LED_APB_ADDR_W-1:0]  paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic                        dout
);
    import led_strip_pkg::*;

    logic      start;
    logic      busy;
    pix_addr_t length;
    tcount_t   t0h;
    tcount_t   t1h;
    tcount_t   tbit;
    tcount_t   treset;

    // memory ports
    logic      wr_en;
    pix_addr_t wr_addr;
    pixel_t    wr_data;
    pix_addr_t rd_addr;
    pixel_t    rd_data;

    led_apb_regs i_regs (
        .clk     (clk),
        .nreset  (nreset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .busy    (busy),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .start   (start),
        .length  (length),
        .t0h     (t0h),
        .t1h     (t1h),
        .tbit    (tbit),
        .treset  (treset),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    pixel_ram i_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    ws2812_encoder i_enc (
        .clk     (clk),
        .nreset  (nreset),
        .start   (start),
        .length  (length),
        .t0h     (t0h),
        .t1h     (t1h),
        .tbit    (tbit),
        .treset  (treset),
        .rd_data (rd_data),
        .rd_addr (rd_addr),
        .busy    (busy),
        .dout    (dout)
    );

endmodule

//--- verification/led_strip_tb.sv
`timescale 1ns/1ns
`include "led_strip_settings.svh"

module led_strip_tb;
    import led_strip_pkg::*;

    logic clk, nreset, psel, penable, pwrite, pready, pslverr, dout;
    logic [`LED_APB_ADDR_W-1:0] paddr;
    logic [31:0] pwdata, prdata;

    logic [7:0]  tr_kind [$];
    logic [31:0] tr_a [$], tr_b [$], tr_c [$];

    pixel_t      m_mem [0:`LED_MAX_PIXELS-1];     // expected pixel memory
    pix_addr_t   m_len;
    tcount_t     m_t0h, m_t1h, m_tbit, m_treset;
    tcount_t     f_t0h, f_t1h, f_tbit, f_treset;  // timing of the frame on the line
    int unsigned f_count, frame_no;

    int unsigned cyc = 0;
    int unsigned rise_cyc = 0;
    int unsigned sample_cyc = 0;
    int unsigned wd_cycles = 0;
    int unsigned width_q [$], rise_q [$];
    logic        dout_q = 1'b0;

    led_strip_top i_dut (
        .clk     (clk),
        .nreset  (nreset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .dout    (dout)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ########################################
    // dout monitor and watchdog
    // ########################################

    always @(posedge clk) cyc <= cyc + 1;

    always @(negedge clk) begin
        if (dout === 1'b1 && !dout_q) begin
            rise_cyc = cyc;
            rise_q.push_back(cyc);
        end
        if (dout === 1'b0 && dout_q) begin
            width_q.push_back(cyc - rise_cyc);  // high width in cycles
        end
        dout_q = (dout === 1'b1);
    end

    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        stop_with_failure("watchdog expired before the trace was finished");
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("[ERROR] %s: expected %0h, actual %0h",
                                        name, expected, actual));
        end
    endtask

    // one apb transfer entered and left on a falling edge
    task automatic apb_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                              output logic [31:0] rd, output logic err);
        int unsigned gap;
        gap     = 1 + ($urandom % 4);
        paddr   = addr[`LED_APB_ADDR_W-1:0];
        pwrite  = wr;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable    = 1'b1;
        rd         = prdata;    // captured by the slave at the setup edge
        err        = pslverr;
        sample_cyc = cyc;
        check("apb pready", 32'd1, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic start_frame(input int unsigned count);
        logic [31:0] rd;
        logic        err;
        frame_no++;
        check("frame pixel count", m_len + 1, count);
        f_count  = count;
        f_t0h    = m_t0h;
        f_t1h    = m_t1h;
        f_tbit   = m_tbit;
        f_treset = m_treset;
        width_q.delete();
        rise_q.delete();
        apb_access(1'b1, 'h000, 32'd1, rd, err);
        apb_access(1'b0, 'h004, 32'd0, rd, err);
        check("status busy during frame", 32'd1, rd);
        apb_access(1'b1, 'h000, 32'd1, rd, err);    // must not restart or extend
        check("pslverr on start while busy", 32'd0, err);
    endtask

    task automatic finish_frame();
        logic [31:0] rd;
        logic        err;
        logic        bit_val;
        int          i;
        do begin
            apb_access(1'b0, 'h004, 32'd0, rd, err);
        end while (rd[0] === 1'b1);
        check($sformatf("frame %0d bit count", frame_no), f_count * 24, width_q.size());
        check($sformatf("frame %0d rising edges", frame_no), f_count * 24, rise_q.size());
        for (i = 0; i < width_q.size(); i++) begin
            bit_val = (width_q[i] == f_t1h);
            if (width_q[i] != f_t1h && width_q[i] != f_t0h) begin
                stop_with_failure($sformatf("frame %0d bit %0d: high width of %0d cycles is %s",
                                  frame_no, i, width_q[i], "neither t0h nor t1h"));
            end
            check($sformatf("frame %0d bit %0d", frame_no, i),
                  m_mem[i / 24][23 - (i % 24)], bit_val);
            if (i > 0) begin
                check($sformatf("frame %0d period %0d", frame_no, i), f_tbit,
                      rise_q[i] - rise_q[i - 1]);
            end
        end
        // latch gap is counted from the end of the last bit
        if (sample_cyc < rise_q[rise_q.size() - 1] + f_tbit + f_treset) begin
            stop_with_failure($sformatf("frame %0d: busy fell before the latch gap ended",
                                        frame_no));
        end
    endtask

    // ########################################
    // trace loading and execution
    // ########################################

    initial begin
        int          fd, n;
        string       line;
        logic [31:0] a, b, c, rd;
        logic        err;
        int unsigned pre_tbit, pre_treset, budget;

        void'($urandom(51));
        {nreset, psel, penable, pwrite, paddr, pwdata} = '0;
        m_len    = '0;
        m_t0h    = `LED_T0H_RST;
        m_t1h    = `LED_T1H_RST;
        m_tbit   = `LED_TBIT_RST;
        m_treset = `LED_TRESET_RST;
        for (n = 0; n < `LED_MAX_PIXELS; n++) m_mem[n] = '0;
        pre_tbit   = `LED_TBIT_RST;
        pre_treset = `LED_TRESET_RST;
        budget     = 2000;

        fd = $fopen("verification/led_strip_trace.txt", "r");
        if (fd == 0) stop_with_failure("could not open the trace file");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 1 || line.getc(0) inside {"#", " ", "\n", "\r"}) continue;
            {a, b, c} = '0;
            void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
            tr_kind.push_back(line.getc(0));
            tr_a.push_back(a);
            tr_b.push_back(b);
            tr_c.push_back(c);
            // the watchdog budget follows the timing the frames will run with
            if (line.getc(0) == "W" && a == 'h014) pre_tbit = b[15:0];
            if (line.getc(0) == "W" && a == 'h018) pre_treset = b[15:0];
            if (line.getc(0) == "F") budget += a * 24 * pre_tbit + pre_treset;
        end
        $fclose(fd);
        wd_cycles = budget;

        repeat (5) @(negedge clk);
        nreset = 1'b1;

        for (n = 0; n < tr_kind.size(); n++) begin
            case (tr_kind[n])
                "W": begin
                    apb_access(1'b1, tr_a[n], tr_b[n], rd, err);
                    if (tr_a[n][11:8] == 4'h1 && tr_a[n][1:0] == 2'b00)
                        m_mem[tr_a[n][`LED_PIX_ADDR_W+1:2]] = tr_b[n][23:0];
                    else if (tr_a[n] == 'h008) m_len = tr_b[n][`LED_PIX_ADDR_W-1:0];
                    else if (tr_a[n] == 'h00C) m_t0h = tr_b[n][15:0];
                    else if (tr_a[n] == 'h010) m_t1h = tr_b[n][15:0];
                    else if (tr_a[n] == 'h014) m_tbit = tr_b[n][15:0];
                    else if (tr_a[n] == 'h018) m_treset = tr_b[n][15:0];
                end
                "R": begin
                    apb_access(1'b0, tr_a[n], 32'd0, rd, err);
                    check($sformatf("read %03h data", tr_a[n]), tr_b[n], rd);
                    check($sformatf("read %03h pslverr", tr_a[n]), tr_c[n], err);
                end
                "F": start_frame(tr_a[n]);
                "I": finish_frame();
                default: stop_with_failure("unknown command in the trace file");
            endcase
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- led_strip_top.f
+incdir+verilog
verilog/led_strip_pkg.sv
verilog/led_apb_regs.sv
verilog/pixel_ram.sv
verilog/ws2812_encoder.sv
verilog/led_strip_top.sv
verification/led_strip_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f led_strip_top.f \
    --top-module led_strip_tb -o led_strip_sim
./obj_dir/led_strip_sim

//--- verification/led_strip_trace.txt
# W addr data | R addr expected_data expected_pslverr | F pixel_count | I (wait idle)
# all numbers hex, addresses are apb byte addresses
R 008 00000000 0
R 00C 00000004 0
R 010 00000008 0
R 014 0000000C 0
R 018 00000032 0
R 000 00000000 0
W 008 00000007
R 008 00000007 0
W 018 00000028
R 018 00000028 0
R 020 00000000 1
R 200 00000000 1
R 104 00000000 0
W 100 00A5C3F0
W 104 00FF0001
W 108 0000FF80
W 10C 00123456
W 110 00800001
W 114 007E55AA
W 118 00C0FFEE
W 11C 00010203
F 8
I
W 00C 00000003
W 010 00000009
W 014 0000000E
R 014 0000000E 0
F 8
I
W 008 00000002
F 3
I
R 000 00000000 0
